/* src/fpu_pkg.sv */
package fpu_pkg;

  // vector types with a meaning of their own
  typedef logic [31:0]        float_t;   // packed binary32 word
  typedef logic [4:0]         flags_t;   // nv dz of uf nx
  typedef logic [2:0]         rm_t;      // frm field
  typedef logic [6:0]         funct7_t;
  typedef logic signed [9:0]  sexp_t;    // unbiased working exponent
  typedef logic [23:0]        sig_t;     // significand incl. hidden bit

  typedef enum logic [1:0] {
    OP_ADD,
    OP_SUB,
    OP_MUL
  } op_e;

  // funct7 encodings that are decoded
  localparam funct7_t F7_ADD = 7'b0000000;
  localparam funct7_t F7_SUB = 7'b0000100;
  localparam funct7_t F7_MUL = 7'b0001000;

  // only round toward zero needs its own code, all else rounds to nearest even
  localparam rm_t RM_RTZ = 3'b001;

  localparam sexp_t EXP_BIAS = 10'sd127;
  localparam sexp_t EXP_MAX  = 10'sd127;   // largest normal exponent
  localparam sexp_t EXP_MIN  = -10'sd126;  // smallest normal exponent

  localparam float_t CANON_NAN = 32'h7fc0_0000;

  // magnitudes used on overflow
  localparam logic [30:0] INF_MAG     = 31'h7f80_0000;
  localparam logic [30:0] MAX_FIN_MAG = 31'h7f7f_ffff;

  // accrued flag masks, bit 4 down to bit 0
  localparam flags_t FLAG_NV = 5'b10000;
  localparam flags_t FLAG_OF = 5'b00100;
  localparam flags_t FLAG_UF = 5'b00010;
  localparam flags_t FLAG_NX = 5'b00001;

  typedef struct packed {
    logic  sign;
    sexp_t exp;    // unbiased
    sig_t  sig;
    logic  zero;   // zero or flushed subnormal
  } operand_t;

  // decode stage output
  typedef struct packed {
    op_e      op;
    rm_t      rm;
    operand_t a;
    operand_t b;
    logic     invalid;  // special input or unknown funct7
  } dec_t;

  // execute stage output, significand not yet rounded
  typedef struct packed {
    logic        sign;
    sexp_t       exp;
    logic [26:0] sig;    // [26:3] significand, [2] guard, [1] round, [0] sticky
    logic        zero;
    logic        invalid;
    rm_t         rm;
  } raw_t;

endpackage

/* src/fpu_decode.sv */
`timescale 1ns/1ps

module fpu_decode
  import fpu_pkg::*;
(
  input  float_t  a,
  input  float_t  b,
  input  funct7_t funct7,
  input  rm_t     frm,
  output dec_t    dec
);

  op_e  op;
  logic bad_op;
  logic special_a;
  logic special_b;

  // splits a binary32 word into sign, unbiased exponent and significand
  function automatic operand_t unpack(input float_t f);
    operand_t o;
    o.sign = f[31];
    o.zero = (f[30:23] == 8'd0);  // subnormals flush to zero
    o.exp  = sexp_t'({2'b00, f[30:23]}) - EXP_BIAS;
    o.sig  = o.zero ? sig_t'(0) : {1'b1, f[22:0]};
    return o;
  endfunction

  always_comb begin
    bad_op = 1'b0;
    case (funct7)
      F7_ADD:  op = OP_ADD;
      F7_SUB:  op = OP_SUB;
      F7_MUL:  op = OP_MUL;
      default: begin
        op     = OP_ADD;  // result is replaced by nan anyway
        bad_op = 1'b1;
      end
    endcase
  end

  // exponent all ones means inf or nan
  assign special_a = &a[30:23];
  assign special_b = &b[30:23];

  assign dec.op      = op;
  assign dec.rm      = frm;
  assign dec.a       = unpack(a);
  assign dec.b       = unpack(b);
  assign dec.invalid = bad_op | special_a | special_b;

endmodule

/* src/fpu_addsub.sv */
`timescale 1ns/1ps

module fpu_addsub
  import fpu_pkg::*;
(
  input  dec_t dec,
  output raw_t raw
);

  logic        sign_a;
  logic        sign_b;     // after the flip for subtract
  sexp_t       exp_a;
  sexp_t       exp_b;
  logic        a_bigger;

  logic        big_sign;
  sexp_t       big_exp;
  sig_t        big_sig;
  logic        sml_sign;
  sexp_t       sml_exp;
  sig_t        sml_sig;

  sexp_t       exp_diff;
  logic [4:0]  shamt;
  logic [53:0] shifted;
  logic [26:0] big_ext;
  logic [26:0] sml_ext;    // aligned, lost bits folded into bit 0
  logic        eff_sub;
  logic [27:0] sum;

  assign sign_a = dec.a.sign;
  assign sign_b = dec.b.sign ^ (dec.op == OP_SUB);
  assign exp_a  = dec.a.exp;
  assign exp_b  = dec.b.exp;

  // magnitude compare, exponent first then significand
  assign a_bigger = (exp_a > exp_b) || ((exp_a == exp_b) && (dec.a.sig >= dec.b.sig));

  always_comb begin
    if (a_bigger) begin
      big_sign = sign_a;
      big_exp  = exp_a;
      big_sig  = dec.a.sig;
      sml_sign = sign_b;
      sml_exp  = exp_b;
      sml_sig  = dec.b.sig;
    end else begin
      big_sign = sign_b;
      big_exp  = exp_b;
      big_sig  = dec.b.sig;
      sml_sign = sign_a;
      sml_exp  = exp_a;
      sml_sig  = dec.a.sig;
    end
  end

  // alignment, anything past 27 places is sticky only
  assign exp_diff = big_exp - sml_exp;
  assign shamt    = (exp_diff > 10'sd27) ? 5'd27 : exp_diff[4:0];
  assign shifted  = {sml_sig, 30'b0} >> shamt;
  assign sml_ext  = {shifted[53:28], shifted[27] | (|shifted[26:0])};
  assign big_ext  = {big_sig, 3'b000};

  assign eff_sub = big_sign ^ sml_sign;
  assign sum     = eff_sub ? ({1'b0, big_ext} - {1'b0, sml_ext})
                           : ({1'b0, big_ext} + {1'b0, sml_ext});

  always_comb begin
    raw.invalid = dec.invalid;
    raw.rm      = dec.rm;
    raw.zero    = (sum == 28'd0);
    raw.sign    = big_sign;
    if (sum[27]) begin
      // carry out, shift right once keeping sticky
      raw.sig = {sum[27:2], sum[1] | sum[0]};
      raw.exp = big_exp + 10'sd1;
    end else begin
      raw.sig = sum[26:0];
      raw.exp = big_exp;
    end
    if (raw.zero && eff_sub)
      raw.sign = 1'b0;  // exact cancellation is +0
  end

endmodule

/* src/fpu_mul.sv */
`timescale 1ns/1ps

module fpu_mul
  import fpu_pkg::*;
(
  input  dec_t dec,
  output raw_t raw
);

  logic [47:0] prod;
  sexp_t       exp_a;
  sexp_t       exp_b;
  sexp_t       exp_sum;
  logic        top_bit;    // product in [2,4)

  assign exp_a   = dec.a.exp;
  assign exp_b   = dec.b.exp;
  assign exp_sum = exp_a + exp_b;

  assign prod    = dec.a.sig * dec.b.sig;
  assign top_bit = prod[47];

  always_comb begin
    raw.invalid = dec.invalid;
    raw.rm      = dec.rm;
    raw.sign    = dec.a.sign ^ dec.b.sign;
    raw.zero    = dec.a.zero | dec.b.zero;  // signed zero
    if (top_bit) begin
      raw.sig = {prod[47:22], |prod[21:0]};
      raw.exp = exp_sum + 10'sd1;
    end else begin
      raw.sig = {prod[46:21], |prod[20:0]};
      raw.exp = exp_sum;
    end
  end

endmodule

/* src/fpu_round.sv */
`timescale 1ns/1ps

module fpu_round
  import fpu_pkg::*;
(
  input  raw_t   raw,
  output float_t result,
  output flags_t flags
);

  logic [4:0]  lz;
  logic [26:0] norm;
  sexp_t       exp_n;      // after left normalize
  sexp_t       exp_in;
  logic        guard;
  logic        rnd;
  logic        sticky;
  logic        inexact;
  logic        round_up;
  logic [24:0] mant_sum;
  logic [22:0] frac;
  sexp_t       exp_r;      // after rounding
  sexp_t       exp_biased;

  // leading zeros above the hidden bit position
  function automatic logic [4:0] lead_zeros(input logic [26:0] v);
    logic [4:0] n;
    logic       found;
    n     = 5'd0;
    found = 1'b0;
    for (int i = 26; i >= 0; i--) begin
      if (!found) begin
        if (v[i])
          found = 1'b1;
        else
          n = n + 5'd1;
      end
    end
    return n;
  endfunction

  assign exp_in = raw.exp;
  assign lz     = lead_zeros(raw.sig);
  assign norm   = raw.sig << lz;  // only moves after a cancellation
  assign exp_n  = exp_in - sexp_t'({5'b00000, lz});

  assign guard   = norm[2];
  assign rnd     = norm[1];
  assign sticky  = norm[0];
  assign inexact = guard | rnd | sticky;

  // nearest even unless toward zero was asked for
  assign round_up = (raw.rm == RM_RTZ) ? 1'b0 : guard & (rnd | sticky | norm[3]);

  assign mant_sum = {1'b0, norm[26:3]} + {24'd0, round_up};

  always_comb begin
    if (mant_sum[24]) begin
      frac  = mant_sum[23:1];  // 1.111.. rounded up to 10.000..
      exp_r = exp_n + 10'sd1;
    end else begin
      frac  = mant_sum[22:0];
      exp_r = exp_n;
    end
  end

  assign exp_biased = exp_r + EXP_BIAS;

  always_comb begin
    result = {raw.sign, exp_biased[7:0], frac};
    flags  = inexact ? FLAG_NX : '0;
    if (raw.invalid) begin
      result = CANON_NAN;
      flags  = FLAG_NV;
    end else if (raw.zero) begin
      result = {raw.sign, 31'd0};
      flags  = '0;
    end else if (exp_r > EXP_MAX) begin
      // toward zero saturates at the largest finite value
      result = (raw.rm == RM_RTZ) ? {raw.sign, MAX_FIN_MAG} : {raw.sign, INF_MAG};
      flags  = FLAG_OF | FLAG_NX;
    end else if (exp_r < EXP_MIN) begin
      result = {raw.sign, 31'd0};  // flush, no subnormal output
      flags  = FLAG_UF | FLAG_NX;
    end
  end

endmodule

/* src/fpu_top.sv */
`timescale 1ns/1ps

module fpu_top
  import fpu_pkg::*;
(
  input  logic    clk,
  input  logic    rst_n,
  input  float_t  floating_point1,
  input  float_t  floating_point2,
  input  funct7_t funct7,
  input  rm_t     frm,
  input  logic    start_sig,
  output float_t  floating_point_out,
  output flags_t  flags,
  output logic    f_ready
);

  dec_t   dec_c;
  dec_t   dec_q;
  raw_t   add_raw;
  raw_t   mul_raw;
  raw_t   raw_c;
  raw_t   raw_q;
  float_t res_c;
  flags_t flags_c;
  logic   valid1;
  logic   valid2;
  logic   valid3;

  fpu_decode u_decode (
    .a      (floating_point1),
    .b      (floating_point2),
    .funct7 (funct7),
    .frm    (frm),
    .dec    (dec_c)
  );

  fpu_addsub u_addsub (
    .dec (dec_q),
    .raw (add_raw)
  );

  fpu_mul u_mul (
    .dec (dec_q),
    .raw (mul_raw)
  );

  assign raw_c = (dec_q.op == OP_MUL) ? mul_raw : add_raw;

  fpu_round u_round (
    .raw    (raw_q),
    .result (res_c),
    .flags  (flags_c)
  );

  // stage payloads load only with a valid request
  always_ff @(posedge clk) begin
    if (start_sig)
      dec_q <= dec_c;
    if (valid1)
      raw_q <= raw_c;
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid1             <= 1'b0;
      valid2             <= 1'b0;
      valid3             <= 1'b0;
      floating_point_out <= '0;
      flags              <= '0;
    end else begin
      valid1 <= start_sig;
      valid2 <= valid1;
      valid3 <= valid2;
      if (valid2) begin  // outputs hold until the next result
        floating_point_out <= res_c;
        flags              <= flags_c;
      end
    end
  end

  assign f_ready = valid3;

endmodule

/* tb/fpu_vectors.svh */
`ifndef FPU_VECTORS_SVH
`define FPU_VECTORS_SVH

// columns: name, operand 1, operand 2, funct7, frm, expected result, expected flags
// flags are nv dz of uf nx, bit 4 down to bit 0

localparam funct7_t FN_ADD = 7'b0000000;
localparam funct7_t FN_SUB = 7'b0000100;
localparam funct7_t FN_MUL = 7'b0001000;
localparam funct7_t FN_DIV = 7'b0001100;  // not implemented

localparam rm_t RNE = 3'b000;
localparam rm_t RTZ = 3'b001;
localparam rm_t RMM = 3'b100;  // falls back to nearest even

localparam flags_t F_NONE = 5'b00000;
localparam flags_t F_NV   = 5'b10000;
localparam flags_t F_OFNX = 5'b00101;
localparam flags_t F_UFNX = 5'b00011;
localparam flags_t F_NX   = 5'b00001;

task automatic add_vec(input string name, input float_t a, input float_t b,
                       input funct7_t f7, input rm_t rm, input float_t res,
                       input flags_t flg);
  vec_t v;
  v.op1 = a;
  v.op2 = b;
  v.f7  = f7;
  v.rm  = rm;
  v.res = res;
  v.flg = flg;
  vec_q.push_back(v);
  name_q.push_back(name);
endtask

task automatic fill_table();
  add_vec("add_exact",      32'h3fc00000, 32'h40100000, FN_ADD, RNE, 32'h40700000, F_NONE);
  add_vec("sub_exact",      32'h40400000, 32'h40a00000, FN_SUB, RNE, 32'hc0000000, F_NONE);
  add_vec("sub_self_pos",   32'h40400000, 32'h40400000, FN_SUB, RNE, 32'h00000000, F_NONE);
  add_vec("sub_self_neg",   32'hc0400000, 32'hc0400000, FN_SUB, RTZ, 32'h00000000, F_NONE);
  add_vec("add_opposite",   32'h40100000, 32'hc0100000, FN_ADD, RNE, 32'h00000000, F_NONE);
  add_vec("sub_cancel",     32'h3f800000, 32'h33800000, FN_SUB, RNE, 32'h3f7fffff, F_NONE);
  add_vec("add_subnormal",  32'h3f800000, 32'h00400000, FN_ADD, RNE, 32'h3f800000, F_NONE);
  add_vec("mul_exact",      32'hbfc00000, 32'h40800000, FN_MUL, RNE, 32'hc0c00000, F_NONE);
  add_vec("mul_zero_neg",   32'h00000000, 32'hc0400000, FN_MUL, RNE, 32'h80000000, F_NONE);
  add_vec("mul_zero_pos",   32'h80000000, 32'hc0000000, FN_MUL, RTZ, 32'h00000000, F_NONE);
  add_vec("mul_subn",       32'h00000001, 32'h40000000, FN_MUL, RNE, 32'h00000000, F_NONE);
  add_vec("mul_subn_neg",   32'h80400000, 32'h3f800000, FN_MUL, RNE, 32'h80000000, F_NONE);
  add_vec("round_rne",      32'h3f800000, 32'h33800001, FN_ADD, RNE, 32'h3f800001, F_NX);
  add_vec("round_rtz",      32'h3f800000, 32'h33800001, FN_ADD, RTZ, 32'h3f800000, F_NX);
  add_vec("round_rmm",      32'h3f800000, 32'h33800001, FN_ADD, RMM, 32'h3f800001, F_NX);
  add_vec("tie_even_down",  32'h3f800000, 32'h33800000, FN_ADD, RNE, 32'h3f800000, F_NX);
  add_vec("tie_even_up",    32'h3f800001, 32'h33800000, FN_ADD, RNE, 32'h3f800002, F_NX);
  add_vec("far_sticky",     32'h3f800000, 32'h30800000, FN_ADD, RNE, 32'h3f800000, F_NX);
  add_vec("ovf_rne",        32'h7f7fffff, 32'h40000000, FN_MUL, RNE, 32'h7f800000, F_OFNX);
  add_vec("ovf_rtz",        32'h7f7fffff, 32'h40000000, FN_MUL, RTZ, 32'h7f7fffff, F_OFNX);
  add_vec("ovf_neg",        32'hff7fffff, 32'h40000000, FN_MUL, RNE, 32'hff800000, F_OFNX);
  add_vec("ufl_pos",        32'h00800000, 32'h3f000000, FN_MUL, RNE, 32'h00000000, F_UFNX);
  add_vec("ufl_neg",        32'h80800000, 32'h3f000000, FN_MUL, RNE, 32'h80000000, F_UFNX);
  add_vec("inf_add",        32'h7f800000, 32'h3f800000, FN_ADD, RNE, 32'h7fc00000, F_NV);
  add_vec("nan_mul",        32'h3f800000, 32'h7fc00000, FN_MUL, RNE, 32'h7fc00000, F_NV);
  add_vec("ninf_sub",       32'h40000000, 32'hff800000, FN_SUB, RTZ, 32'h7fc00000, F_NV);
  add_vec("bad_funct7",     32'h3f800000, 32'h40000000, FN_DIV, RNE, 32'h7fc00000, F_NV);
endtask

`endif

/* tb/tb_fpu_top.sv */
`timescale 1ns/1ps

module tb_fpu_top
  import fpu_pkg::*;
();

  localparam int NUM_PASSES = 2;  // second pass runs back to back

  typedef struct packed {
    float_t  op1;
    float_t  op2;
    funct7_t f7;
    rm_t     rm;
    float_t  res;   // expected word
    flags_t  flg;   // expected flags
  } vec_t;

  logic    clk;
  logic    rst_n;
  float_t  floating_point1;
  float_t  floating_point2;
  funct7_t funct7;
  rm_t     frm;
  logic    start_sig;
  float_t  floating_point_out;
  flags_t  flags;
  logic    f_ready;

  vec_t        vec_q[$];
  string       name_q[$];
  int          idx_q[$];    // table index of each request in flight
  int          start_q[$];  // negedge count at each start
  int          neg_cnt;
  logic [31:0] lfsr;
  string       held_name;   // last result expected on the outputs
  float_t      held_res;
  flags_t      held_flg;

  fpu_top u_fpu_top (
    .clk                (clk),
    .rst_n              (rst_n),
    .floating_point1    (floating_point1),
    .floating_point2    (floating_point2),
    .funct7             (funct7),
    .frm                (frm),
    .start_sig          (start_sig),
    .floating_point_out (floating_point_out),
    .flags              (flags),
    .f_ready            (f_ready)
  );

  `include "fpu_vectors.svh"

  always #20 clk = ~clk;

  // taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic abort_run();
    $display("Test failed");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_value(input string test_name, input string what,
                             input logic [31:0] expected, input logic [31:0] actual);
    if (actual !== expected) begin
      $display("FAILED %s %s expected %h actual %h", test_name, what, expected, actual);
      abort_run();
    end
  endtask

  initial begin
    logic [1:0] gap;
    clk             = 1'b0;
    rst_n           = 1'b0;
    floating_point1 = '0;
    floating_point2 = '0;
    funct7          = '0;
    frm             = '0;
    start_sig       = 1'b0;
    neg_cnt         = 0;
    lfsr            = 32'h167d_2453;
    held_name       = "reset";
    held_res        = '0;
    held_flg        = '0;
    fill_table();
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    for (int p = 0; p < NUM_PASSES; p++) begin
      for (int i = 0; i < vec_q.size(); i++) begin
        floating_point1 <= vec_q[i].op1;
        floating_point2 <= vec_q[i].op2;
        funct7          <= vec_q[i].f7;
        frm             <= vec_q[i].rm;
        start_sig       <= 1'b1;
        idx_q.push_back(i);
        gap = 2'd0;
        if (p == 0) begin  // one lfsr step per gap bit
          lfsr   = lfsr_next(lfsr);
          gap[0] = lfsr[0];
          lfsr   = lfsr_next(lfsr);
          gap[1] = lfsr[0];
        end
        @(posedge clk);
        repeat (gap) begin
          start_sig <= 1'b0;
          @(posedge clk);
        end
      end
    end
    start_sig <= 1'b0;
    while (idx_q.size() != 0)
      @(posedge clk);
    repeat (4) @(posedge clk);  // room for a stray f_ready
    $display("Test passed");
    $finish;
  end

  // results and their timing sampled mid cycle
  always @(negedge clk) begin
    int idx;
    neg_cnt = neg_cnt + 1;
    if (f_ready && start_q.size() == 0) begin
      $display("f_ready came with no request outstanding");
      abort_run();
    end else if (f_ready && start_q[0] != neg_cnt - 3) begin
      $display("f_ready came %0d cycles after its start", neg_cnt - start_q[0]);
      abort_run();
    end else if (!f_ready && start_q.size() != 0 && neg_cnt - start_q[0] >= 3) begin
      $display("no f_ready for a request started %0d cycles ago", neg_cnt - start_q[0]);
      abort_run();
    end else begin
      if (f_ready) begin
        void'(start_q.pop_front());
        idx = idx_q.pop_front();
        check_value(name_q[idx], "result", vec_q[idx].res, floating_point_out);
        check_value(name_q[idx], "flags", {27'd0, vec_q[idx].flg}, {27'd0, flags});
        held_name = name_q[idx];
        held_res  = vec_q[idx].res;
        held_flg  = vec_q[idx].flg;
      end else if (rst_n) begin
        // outputs keep the last result between strobes
        check_value(held_name, "held result", held_res, floating_point_out);
        check_value(held_name, "held flags", {27'd0, held_flg}, {27'd0, flags});
      end
      if (start_sig)
        start_q.push_back(neg_cnt);
    end
  end

  // watchdog sized from the number of requests
  initial begin
    int limit;
    @(posedge clk);
    limit = NUM_PASSES * vec_q.size() * 8 + 20;
    repeat (limit) @(posedge clk);
    $display("timeout after %0d cycles with results still missing", limit);
    abort_run();
  end

endmodule

/* tb.f */
src/fpu_pkg.sv
src/fpu_decode.sv
src/fpu_addsub.sv
src/fpu_mul.sv
src/fpu_round.sv
src/fpu_top.sv
+incdir+tb
tb/tb_fpu_top.sv

/* run_sim.sh */
#!/bin/sh
# build and run the fpu testbench with verilator, exit status gives pass or fail
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal \
  --top-module tb_fpu_top \
  -f tb.f \
  -o sim_tb_fpu_top \
  && ./obj_dir/sim_tb_fpu_top \
  || { echo "simulation did not pass"; exit 1; }
